/* all.f */
src/thrd_cfg_pkg.sv
src/thrd_cmd_pkg.sv
src/active_thread_table.sv
src/thrd_request_regs.sv
src/thread_scheduler.sv
src/thread_manager.sv
testbench/tb_thread_manager.sv

/* src/active_thread_table.sv */
`timescale 1ns/1ps

module active_thread_table
  import thrd_cfg_pkg::*;
(
  input  logic               clk,
  // read port, data one cycle after the index
  input  logic [IDX_W-1:0]   rd_idx_i,
  // write port, word and sleep counter written separately
  input  logic               word_we_i,
  input  logic               sleep_we_i,
  input  logic [IDX_W-1:0]   wr_idx_i,
  input  logic [THRD_W-1:0]  wr_word_i,
  input  logic [SLEEP_W-1:0] wr_sleep_i,
  output logic [THRD_W-1:0]  rd_word_o,
  output logic [SLEEP_W-1:0] rd_sleep_o
);

  // thread words of the active loop
  logic [THRD_W-1:0]  word_mem  [PROC_QUANTITY];
  // remaining sleep passes per slot
  logic [SLEEP_W-1:0] sleep_mem [PROC_QUANTITY];

  // word write on fork and on remove-move
  always_ff @(posedge clk) begin
    if (word_we_i) begin
      word_mem[wr_idx_i] <= wr_word_i;
    end
  end

  // counter write on fork, move, pause and every sleeping visit
  always_ff @(posedge clk) begin
    if (sleep_we_i) begin
      sleep_mem[wr_idx_i] <= wr_sleep_i;
    end
  end

  // registered read
  // same cycle write to the read slot returns the old value
  always_ff @(posedge clk) begin
    rd_word_o  <= word_mem[rd_idx_i];
    rd_sleep_o <= sleep_mem[rd_idx_i];
  end

  // scheduler must never address past the table
  // matters once PROC_QUANTITY is not a power of two
  a_wr_idx_range: assert property (@(posedge clk)
    (word_we_i || sleep_we_i) |-> (wr_idx_i < PROC_QUANTITY));

endmodule

/* src/thrd_cfg_pkg.sv */
package thrd_cfg_pkg;

  // thread word fields
  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  // context data sits above the start address
  localparam int THRD_W = DATA_W + ADDR_W;

  // active loop size
  localparam int PROC_QUANTITY = 8;
  localparam int IDX_W = $clog2(PROC_QUANTITY);
  // count goes up to PROC_QUANTITY itself, so one bit more than an index
  localparam int CNT_W = IDX_W + 1;

  // visits a paused thread is skipped
  localparam int SLEEP_TIMEOUT = 4;
  localparam int SLEEP_W = $clog2(SLEEP_TIMEOUT + 1);

  // visits a stop or pause request survives without a match
  localparam int REQ_LIFETIME = PROC_QUANTITY;
  localparam int LIFE_W = $clog2(REQ_LIFETIME + 1);

  // scheduler FSM encoding
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
  localparam logic [ST_W-1:0] ST_FETCH   = 3'd1;
  localparam logic [ST_W-1:0] ST_EXAMINE = 3'd2;
  localparam logic [ST_W-1:0] ST_MOVE    = 3'd3;
  localparam logic [ST_W-1:0] ST_DELIVER = 3'd4;

endpackage

/* src/thrd_cmd_pkg.sv */
package thrd_cmd_pkg;

  // command code on cmd_i
  localparam int CMD_W = 8;

  // queue a new thread for fork
  localparam logic [CMD_W-1:0] THREAD_CMD_RUN   = 8'h01;
  // mark one thread for removal
  localparam logic [CMD_W-1:0] THREAD_CMD_STOP  = 8'h02;
  // put one thread to sleep for SLEEP_TIMEOUT passes
  localparam logic [CMD_W-1:0] THREAD_CMD_PAUSE = 8'h03;

  // result code returned with cmd_done_o
  localparam int RSLT_W = 2;
  localparam logic [RSLT_W-1:0] RSLT_REJECT = 2'd0;
  localparam logic [RSLT_W-1:0] RSLT_ACCEPT = 2'd1;

  // acknowledge words, same width as the context data field
  localparam int ACK_W = 32;

  // data returned for an accepted RUN
  localparam logic [ACK_W-1:0] RUN_ACK_WORD  = 32'hdeadbeef;
  // data returned for an accepted STOP
  localparam logic [ACK_W-1:0] STOP_ACK_WORD = 32'hbeefdead;

  // pause never reports accept
  // its data is always zero

endpackage

/* src/thrd_request_regs.sv */
`timescale 1ns/1ps

module thrd_request_regs
  import thrd_cfg_pkg::*;
  import thrd_cmd_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid_i,
  input  logic [CMD_W-1:0]  cmd_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              fork_take_i,
  input  logic              stop_clear_i,
  input  logic              pause_clear_i,
  input  logic              visit_i,
  output logic              cmd_done_o,
  output logic [RSLT_W-1:0] thrd_rslt_o,
  output logic [DATA_W-1:0] data_o,
  output logic              fork_pending_o,
  output logic [THRD_W-1:0] fork_word_o,
  output logic              stop_pending_o,
  output logic [THRD_W-1:0] stop_word_o,
  output logic              pause_pending_o,
  output logic [THRD_W-1:0] pause_word_o
);

  logic [THRD_W-1:0] cmd_word;
  logic              is_run;
  logic              is_stop;
  logic              is_pause;
  logic              run_ok;
  logic              stop_ok;

  // stop request in bit 0, pause request in bit 1
  logic [1:0]        req_set;
  logic [1:0]        req_clear;
  logic [1:0]        req_pend;
  logic [THRD_W-1:0] req_word [2];
  logic [LIFE_W-1:0] req_life [2];

  // thread word as stored in the table
  assign cmd_word = {data_i, addr_i};

  assign is_run   = cmd_valid_i && (cmd_i == THREAD_CMD_RUN);
  assign is_stop  = cmd_valid_i && (cmd_i == THREAD_CMD_STOP);
  assign is_pause = cmd_valid_i && (cmd_i == THREAD_CMD_PAUSE);

  // a busy single entry register rejects
  assign run_ok  = is_run && !fork_pending_o;
  assign stop_ok = is_stop && !req_pend[0];

  // pause is recorded silently, never reported as accepted
  assign req_set   = {is_pause && !req_pend[1], stop_ok};
  assign req_clear = {pause_clear_i, stop_clear_i};

  // acknowledge one cycle after the strobe
  // unknown codes get reject and zero
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_done_o  <= 1'b0;
      thrd_rslt_o <= RSLT_REJECT;
      data_o      <= '0;
    end else begin
      cmd_done_o  <= cmd_valid_i;
      thrd_rslt_o <= (run_ok || stop_ok) ? RSLT_ACCEPT : RSLT_REJECT;
      if (run_ok) begin
        data_o <= RUN_ACK_WORD;
      end else if (stop_ok) begin
        data_o <= STOP_ACK_WORD;
      end else begin
        data_o <= '0;
      end
    end
  end

  // boot thread (all zero) waits in the fork slot after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      fork_pending_o <= 1'b1;
      fork_word_o    <= '0;
    end else if (run_ok) begin
      fork_pending_o <= 1'b1;
      fork_word_o    <= cmd_word;
    end else if (fork_take_i) begin
      fork_pending_o <= 1'b0;
    end
  end

  // stop and pause flags
  // match clears first, otherwise drop on the last visit of the lifetime
  always_ff @(posedge clk) begin
    if (rst) begin
      req_pend <= '0;
    end else begin
      for (int r = 0; r < 2; r++) begin
        if (req_set[r]) begin
          req_pend[r] <= 1'b1;
        end else if (req_clear[r]) begin
          req_pend[r] <= 1'b0;
        end else if (visit_i && req_pend[r] && (req_life[r] == LIFE_W'(1))) begin
          req_pend[r] <= 1'b0;
        end
      end
    end
  end

  // request payload and lifetime countdown
  always_ff @(posedge clk) begin
    for (int r = 0; r < 2; r++) begin
      if (req_set[r]) begin
        req_word[r] <= cmd_word;
        req_life[r] <= LIFE_W'(REQ_LIFETIME);
      end else if (visit_i && req_pend[r]) begin
        req_life[r] <= req_life[r] - 1'b1;
      end
    end
  end

  assign stop_pending_o  = req_pend[0];
  assign stop_word_o     = req_word[0];
  assign pause_pending_o = req_pend[1];
  assign pause_word_o    = req_word[1];

  // every strobe answered exactly one cycle later, never otherwise
  a_done_after_valid: assert property (@(posedge clk) disable iff (rst)
    cmd_done_o == $past(cmd_valid_i));

endmodule

/* src/thread_manager.sv */
`timescale 1ns/1ps

module thread_manager
  import thrd_cfg_pkg::*;
  import thrd_cmd_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // command side
  input  logic              cmd_valid_i,
  input  logic [CMD_W-1:0]  cmd_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              cmd_done_o,
  output logic [RSLT_W-1:0] thrd_rslt_o,
  output logic [DATA_W-1:0] data_o,
  // scheduling side
  input  logic              next_thread_i,
  output logic              next_valid_o,
  output logic [ADDR_W-1:0] next_proc_o,
  output logic [DATA_W-1:0] next_data_o
);

  // scheduler to request registers
  logic               fork_take;
  logic               stop_clear;
  logic               pause_clear;
  logic               visit;

  // pending requests
  logic               fork_pending;
  logic [THRD_W-1:0]  fork_word;
  logic               stop_pending;
  logic [THRD_W-1:0]  stop_word;
  logic               pause_pending;
  logic [THRD_W-1:0]  pause_word;

  // table ports
  logic [IDX_W-1:0]   rd_idx;
  logic [THRD_W-1:0]  rd_word;
  logic [SLEEP_W-1:0] rd_sleep;
  logic               word_we;
  logic               sleep_we;
  logic [IDX_W-1:0]   wr_idx;
  logic [THRD_W-1:0]  wr_word;
  logic [SLEEP_W-1:0] wr_sleep;

  // command decode, acknowledge and request holding
  thrd_request_regs u_req (
    .clk             (clk),
    .rst             (rst),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_i           (cmd_i),
    .data_i          (data_i),
    .addr_i          (addr_i),
    .fork_take_i     (fork_take),
    .stop_clear_i    (stop_clear),
    .pause_clear_i   (pause_clear),
    .visit_i         (visit),
    .cmd_done_o      (cmd_done_o),
    .thrd_rslt_o     (thrd_rslt_o),
    .data_o          (data_o),
    .fork_pending_o  (fork_pending),
    .fork_word_o     (fork_word),
    .stop_pending_o  (stop_pending),
    .stop_word_o     (stop_word),
    .pause_pending_o (pause_pending),
    .pause_word_o    (pause_word)
  );

  // round robin walk over the active loop
  thread_scheduler u_sched (
    .clk             (clk),
    .rst             (rst),
    .next_thread_i   (next_thread_i),
    .fork_pending_i  (fork_pending),
    .fork_word_i     (fork_word),
    .stop_pending_i  (stop_pending),
    .stop_word_i     (stop_word),
    .pause_pending_i (pause_pending),
    .pause_word_i    (pause_word),
    .rd_word_i       (rd_word),
    .rd_sleep_i      (rd_sleep),
    .next_valid_o    (next_valid_o),
    .next_proc_o     (next_proc_o),
    .next_data_o     (next_data_o),
    .fork_take_o     (fork_take),
    .stop_clear_o    (stop_clear),
    .pause_clear_o   (pause_clear),
    .visit_o         (visit),
    .rd_idx_o        (rd_idx),
    .word_we_o       (word_we),
    .sleep_we_o      (sleep_we),
    .wr_idx_o        (wr_idx),
    .wr_word_o       (wr_word),
    .wr_sleep_o      (wr_sleep)
  );

  // thread words and sleep counters
  active_thread_table u_tbl (
    .clk        (clk),
    .rd_idx_i   (rd_idx),
    .word_we_i  (word_we),
    .sleep_we_i (sleep_we),
    .wr_idx_i   (wr_idx),
    .wr_word_i  (wr_word),
    .wr_sleep_i (wr_sleep),
    .rd_word_o  (rd_word),
    .rd_sleep_o (rd_sleep)
  );

endmodule

/* src/thread_scheduler.sv */
`timescale 1ns/1ps

module thread_scheduler
  import thrd_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               next_thread_i,
  // pending requests
  input  logic               fork_pending_i,
  input  logic [THRD_W-1:0]  fork_word_i,
  input  logic               stop_pending_i,
  input  logic [THRD_W-1:0]  stop_word_i,
  input  logic               pause_pending_i,
  input  logic [THRD_W-1:0]  pause_word_i,
  // table read data
  input  logic [THRD_W-1:0]  rd_word_i,
  input  logic [SLEEP_W-1:0] rd_sleep_i,
  // next thread answer
  output logic               next_valid_o,
  output logic [ADDR_W-1:0]  next_proc_o,
  output logic [DATA_W-1:0]  next_data_o,
  // request register handshakes
  output logic               fork_take_o,
  output logic               stop_clear_o,
  output logic               pause_clear_o,
  output logic               visit_o,
  // table access
  output logic [IDX_W-1:0]   rd_idx_o,
  output logic               word_we_o,
  output logic               sleep_we_o,
  output logic [IDX_W-1:0]   wr_idx_o,
  output logic [THRD_W-1:0]  wr_word_o,
  output logic [SLEEP_W-1:0] wr_sleep_o
);

  logic [ST_W-1:0]  state;
  // loop index and number of active entries
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] count;
  // one next request held back during a walk
  logic             waiting;

  logic [IDX_W-1:0] last_idx;
  logic [IDX_W-1:0] idx_next;
  logic             in_idle;
  logic             in_exam;
  logic             in_move;
  logic             start;
  logic             full;
  logic             take_fork;
  logic             stop_hit;
  logic             pause_hit;
  logic             asleep;

  assign in_idle = (state == ST_IDLE);
  assign in_exam = (state == ST_EXAMINE);
  assign in_move = (state == ST_MOVE);

  assign last_idx = IDX_W'(count - 1'b1);
  // round robin over count entries only
  assign idx_next = (idx == last_idx) ? '0 : idx + 1'b1;

  assign start = next_thread_i || waiting;
  assign full  = (count == CNT_W'(PROC_QUANTITY));

  // fork goes first, it waits while the loop is full
  assign take_fork = in_idle && start && fork_pending_i && !full;

  // slot decisions in examine, stop before pause before sleep
  // the last thread in the loop is never removed
  assign stop_hit  = in_exam && stop_pending_i && (rd_word_i == stop_word_i) &&
                     (count > CNT_W'(1));
  assign pause_hit = in_exam && !stop_hit && pause_pending_i &&
                     (rd_word_i == pause_word_i);
  assign asleep    = in_exam && !stop_hit && !pause_hit && (rd_sleep_i != '0);

  assign fork_take_o   = take_fork;
  assign stop_clear_o  = stop_hit;
  assign pause_clear_o = pause_hit;
  assign visit_o       = in_exam;

  // examine fetches the last entry in case it moves into a removed slot
  assign rd_idx_o = in_exam ? last_idx : idx;

  // table writes
  always_comb begin
    word_we_o  = 1'b0;
    sleep_we_o = 1'b0;
    wr_idx_o   = idx;
    wr_word_o  = rd_word_i;
    wr_sleep_o = rd_sleep_i;
    if (take_fork) begin
      // append at slot count, awake
      word_we_o  = 1'b1;
      sleep_we_o = 1'b1;
      wr_idx_o   = IDX_W'(count);
      wr_word_o  = fork_word_i;
      wr_sleep_o = '0;
    end else if (in_move) begin
      // last entry with its counter into the removed slot
      word_we_o  = 1'b1;
      sleep_we_o = 1'b1;
    end else if (pause_hit) begin
      sleep_we_o = 1'b1;
      wr_sleep_o = SLEEP_W'(SLEEP_TIMEOUT);
    end else if (asleep) begin
      sleep_we_o = 1'b1;
      wr_sleep_o = rd_sleep_i - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      idx          <= '0;
      count        <= '0;
      waiting      <= 1'b0;
      next_valid_o <= 1'b0;
      next_proc_o  <= '0;
      next_data_o  <= '0;
    end else begin
      next_valid_o <= 1'b0;
      if (next_thread_i && !in_idle) begin
        waiting <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (start) begin
            waiting <= 1'b0;
            if (take_fork) begin
              // new thread runs at once, index stays
              count        <= count + 1'b1;
              {next_data_o, next_proc_o} <= fork_word_i;
              next_valid_o <= 1'b1;
              state        <= ST_DELIVER;
            end else if (count != '0) begin
              state <= ST_FETCH;
            end
          end
        end
        // read of idx in flight
        ST_FETCH: begin
          state <= ST_EXAMINE;
        end
        ST_EXAMINE: begin
          if (stop_hit) begin
            if (idx == last_idx) begin
              // removing the tail, nothing to move
              idx   <= '0;
              count <= count - 1'b1;
              state <= ST_FETCH;
            end else begin
              state <= ST_MOVE;
            end
          end else if (pause_hit || asleep) begin
            idx   <= idx_next;
            state <= ST_FETCH;
          end else begin
            {next_data_o, next_proc_o} <= rd_word_i;
            next_valid_o <= 1'b1;
            idx          <= idx_next;
            state        <= ST_DELIVER;
          end
        end
        // walk resumes at the same index with the moved entry
        ST_MOVE: begin
          count <= count - 1'b1;
          state <= ST_FETCH;
        end
        // next_valid_o high in this cycle
        ST_DELIVER: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // answers are single pulses, DELIVER always returns through IDLE
  a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
    next_valid_o |=> !next_valid_o);

  // fork never appends beyond the table
  a_count_range: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(PROC_QUANTITY));

endmodule

/* testbench/tb_thread_manager.sv */
`timescale 1ns/1ps

module tb_thread_manager
  import thrd_cfg_pkg::*;
  import thrd_cmd_pkg::*;
();

  localparam int HALF_PERIOD = 50;
  localparam int MAX_STEPS   = 64;
  // upper bound on cycles for one step
  localparam int STEP_CYCLES = 40;
  localparam STEP_FILE = "testbench/tb_thread_manager_input.txt";

  logic              clk;
  logic              rst;
  logic              cmd_valid;
  logic [CMD_W-1:0]  cmd;
  logic [DATA_W-1:0] data_in;
  logic [ADDR_W-1:0] addr;
  logic              cmd_done;
  logic [RSLT_W-1:0] thrd_rslt;
  logic [DATA_W-1:0] data_out;
  logic              next_thread;
  logic              next_valid;
  logic [ADDR_W-1:0] next_proc;
  logic [DATA_W-1:0] next_data;

  // steps as read from the input file
  logic              step_is_cmd [MAX_STEPS];
  logic [CMD_W-1:0]  step_cmd    [MAX_STEPS];
  logic [DATA_W-1:0] step_data   [MAX_STEPS];
  logic [ADDR_W-1:0] step_addr   [MAX_STEPS];
  logic [RSLT_W-1:0] step_rslt   [MAX_STEPS];
  logic [THRD_W-1:0] step_exp    [MAX_STEPS];

  int                n_steps;
  int                pass_cnt;
  int                fail_cnt;
  int                step_errs;
  logic              loaded;
  reg [8*128-1:0]    skip_buf;

  thread_manager uut (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .data_i        (data_in),
    .addr_i        (addr),
    .cmd_done_o    (cmd_done),
    .thrd_rslt_o   (thrd_rslt),
    .data_o        (data_out),
    .next_thread_i (next_thread),
    .next_valid_o  (next_valid),
    .next_proc_o   (next_proc),
    .next_data_o   (next_data)
  );

  always #HALF_PERIOD clk = ~clk;

  // comment lines start with #, step lines with C or N
  task automatic load_steps();
    int                fd;
    int                c;
    int                code;
    logic [CMD_W-1:0]  f_cmd;
    logic [DATA_W-1:0] f_data;
    logic [ADDR_W-1:0] f_addr;
    logic [RSLT_W-1:0] f_rslt;
    logic [THRD_W-1:0] f_exp;
    fd = $fopen(STEP_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STEP_FILE);
    end else begin
      c = $fgetc(fd);
      while (c != -1 && n_steps < MAX_STEPS) begin
        if (c == "#") begin
          code = $fgets(skip_buf, fd);
        end else if (c == "C" || c == "N") begin
          code = $fscanf(fd, " %h %h %h %h %h", f_cmd, f_data, f_addr, f_rslt, f_exp);
          if (code == 5) begin
            step_is_cmd[n_steps] = (c == "C");
            step_cmd[n_steps]    = f_cmd;
            step_data[n_steps]   = f_data;
            step_addr[n_steps]   = f_addr;
            step_rslt[n_steps]   = f_rslt;
            step_exp[n_steps]    = f_exp;
            n_steps++;
          end else begin
            $display("malformed stimulus line after step %0d", n_steps);
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic compare_field(input string name, input logic [THRD_W-1:0] got,
                               input logic [THRD_W-1:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      step_errs++;
    end
  endtask

  // strobe for one cycle, acknowledge sits in the following cycle
  task automatic run_command(input int s);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = step_cmd[s];
    data_in   = step_data[s];
    addr      = step_addr[s];
    @(negedge clk);
    cmd_valid = 1'b0;
    compare_field("cmd_done_o", cmd_done, 1);
    compare_field("thrd_rslt_o", thrd_rslt, step_rslt[s]);
    compare_field("data_o", data_out, step_exp[s]);
  endtask

  // latency depends on the walk, so poll for the pulse
  task automatic run_next(input int s);
    int   waited;
    logic seen;
    @(negedge clk);
    next_thread = 1'b1;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < STEP_CYCLES) begin
      @(negedge clk);
      next_thread = 1'b0;
      waited++;
      seen = next_valid;
    end
    assert (seen) else begin
      $display("no next_valid_o pulse within %0d cycles in step %0d", STEP_CYCLES, s + 1);
      step_errs++;
    end
    if (seen) begin
      compare_field("next_proc_o", next_proc, step_exp[s][ADDR_W-1:0]);
      compare_field("next_data_o", next_data, step_exp[s][THRD_W-1:ADDR_W]);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    cmd_valid   = 1'b0;
    cmd         = '0;
    data_in     = '0;
    addr        = '0;
    next_thread = 1'b0;
    n_steps     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    loaded      = 1'b0;
    load_steps();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // outputs straight out of reset
    step_errs = 0;
    compare_field("cmd_done_o", cmd_done, 0);
    compare_field("data_o", data_out, 0);
    compare_field("next_valid_o", next_valid, 0);
    compare_field("next_proc_o", next_proc, 0);
    compare_field("next_data_o", next_data, 0);
    assert (n_steps > 0) else begin
      $display("no test steps read from %s", STEP_FILE);
      step_errs++;
    end
    if (step_errs == 0) begin
      pass_cnt++;
      $display("reset values: ok");
    end else begin
      fail_cnt++;
      $display("reset values: failed");
    end
    for (int s = 0; s < n_steps; s++) begin
      step_errs = 0;
      if (step_is_cmd[s]) begin
        run_command(s);
      end else begin
        run_next(s);
      end
      if (step_errs == 0) begin
        pass_cnt++;
        $display("step %0d %s cmd %0h: ok", s + 1, step_is_cmd[s] ? "C" : "N", step_cmd[s]);
      end else begin
        fail_cnt++;
        $display("step %0d %s cmd %0h: failed", s + 1, step_is_cmd[s] ? "C" : "N", step_cmd[s]);
      end
    end
    $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog budget grows with the number of steps
  initial begin
    wait (loaded);
    repeat ((n_steps + 1) * STEP_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish",
             (n_steps + 1) * STEP_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* testbench/tb_thread_manager_input.txt */
# columns kind cmd data addr rslt expect (cmd 01 run, 02 stop, 03 pause)
# expect is data_o for C lines and the thread word {data, addr} for N lines
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 000000000000
C 01 11111111 0100 1 deadbeef
C 01 22222222 0200 0 00000000
N 00 00000000 0000 0 111111110100
C 01 22222222 0200 1 deadbeef
N 00 00000000 0000 0 222222220200
C 01 33333333 0300 1 deadbeef
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 111111110100
N 00 00000000 0000 0 222222220200
N 00 00000000 0000 0 333333330300
C 02 22222222 0200 1 beefdead
C 02 11111111 0100 0 00000000
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 111111110100
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
C 03 11111111 0100 0 00000000
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 333333330300
N 00 00000000 0000 0 000000000000
N 00 00000000 0000 0 111111110100
N 00 00000000 0000 0 333333330300
